//--- verilog/mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int REG_W   = 32;	// data word.
	localparam int RADDR_W = 5;	// register file address.
	localparam int IMM_W   = 16;
	localparam int OPC_W   = 6;
	localparam int SHAMT_W = 5;
	localparam int FUNCT_W = 6;

	// register format.
	typedef struct packed {
		logic [OPC_W-1:0]   opcode;
		logic [RADDR_W-1:0] rs;
		logic [RADDR_W-1:0] rt;
		logic [RADDR_W-1:0] rd;
		logic [SHAMT_W-1:0] shamt;
		logic [FUNCT_W-1:0] funct;
	} inst_r_t;

	// immediate format, same 32 bits.
	typedef struct packed {
		logic [OPC_W-1:0]   opcode;
		logic [RADDR_W-1:0] rs;
		logic [RADDR_W-1:0] rt;
		logic [IMM_W-1:0]   imm;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

endpackage

//--- verilog/exe_op_pkg.sv
package exe_op_pkg;

	localparam int OP_W = 8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operation codes, as sent by the decoder.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [OP_W-1:0] OP_NOP   = 8'b0000_0000;
	localparam logic [OP_W-1:0] OP_AND   = 8'b0010_0100;
	localparam logic [OP_W-1:0] OP_OR    = 8'b0010_0101;
	localparam logic [OP_W-1:0] OP_XOR   = 8'b0010_0110;
	localparam logic [OP_W-1:0] OP_NOR   = 8'b0010_0111;

	localparam logic [OP_W-1:0] OP_SLL   = 8'b0111_1100;	// by shamt.
	localparam logic [OP_W-1:0] OP_SRL   = 8'b0000_0010;
	localparam logic [OP_W-1:0] OP_SRA   = 8'b0000_0011;
	localparam logic [OP_W-1:0] OP_SLLV  = 8'b0000_0100;	// by register.
	localparam logic [OP_W-1:0] OP_SRLV  = 8'b0000_0110;
	localparam logic [OP_W-1:0] OP_SRAV  = 8'b0000_0111;

	localparam logic [OP_W-1:0] OP_ADD   = 8'b0010_0000;
	localparam logic [OP_W-1:0] OP_ADDU  = 8'b0010_0001;
	localparam logic [OP_W-1:0] OP_SUB   = 8'b0010_0010;
	localparam logic [OP_W-1:0] OP_SUBU  = 8'b0010_0011;
	localparam logic [OP_W-1:0] OP_ADDI  = 8'b0101_0101;
	localparam logic [OP_W-1:0] OP_ADDIU = 8'b0101_0110;

	localparam logic [OP_W-1:0] OP_SLT   = 8'b0010_1010;
	localparam logic [OP_W-1:0] OP_SLTU  = 8'b0010_1011;
	localparam logic [OP_W-1:0] OP_SLTI  = 8'b0101_0111;
	localparam logic [OP_W-1:0] OP_SLTIU = 8'b0101_1000;

	// traps, register then immediate forms.
	localparam logic [OP_W-1:0] OP_TGE   = 8'b0011_0000;
	localparam logic [OP_W-1:0] OP_TGEU  = 8'b0011_0001;
	localparam logic [OP_W-1:0] OP_TLT   = 8'b0011_0010;
	localparam logic [OP_W-1:0] OP_TLTU  = 8'b0011_0011;
	localparam logic [OP_W-1:0] OP_TEQ   = 8'b0011_0100;
	localparam logic [OP_W-1:0] OP_TNE   = 8'b0011_0110;
	localparam logic [OP_W-1:0] OP_TGEI  = 8'b0100_0100;
	localparam logic [OP_W-1:0] OP_TGEIU = 8'b0100_0101;
	localparam logic [OP_W-1:0] OP_TLTI  = 8'b0100_0110;
	localparam logic [OP_W-1:0] OP_TLTIU = 8'b0100_0111;
	localparam logic [OP_W-1:0] OP_TEQI  = 8'b0100_1000;
	localparam logic [OP_W-1:0] OP_TNEI  = 8'b0100_1001;

	localparam logic [OP_W-1:0] OP_MFHI  = 8'b0001_0000;
	localparam logic [OP_W-1:0] OP_MTHI  = 8'b0001_0001;
	localparam logic [OP_W-1:0] OP_MFLO  = 8'b0001_0010;
	localparam logic [OP_W-1:0] OP_MTLO  = 8'b0001_0011;
	localparam logic [OP_W-1:0] OP_MULT  = 8'b0001_1000;
	localparam logic [OP_W-1:0] OP_MULTU = 8'b0001_1001;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result types and exception word layout.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int TYPE_W = 3;

	localparam logic [TYPE_W-1:0] TYPE_NONE  = 3'b000;
	localparam logic [TYPE_W-1:0] TYPE_LOGIC = 3'b001;
	localparam logic [TYPE_W-1:0] TYPE_SHIFT = 3'b010;
	localparam logic [TYPE_W-1:0] TYPE_MOVE  = 3'b011;
	localparam logic [TYPE_W-1:0] TYPE_ARITH = 3'b100;

	localparam int EXC_OV_BIT   = 11;
	localparam int EXC_TRAP_BIT = 10;
	localparam int EXC_CLEAR_W  = 8;	// low field, cleared in this stage.

endpackage

//--- verilog/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
	input  logic [exe_op_pkg::OP_W-1:0]    op_i,
	input  logic [mips_isa_pkg::REG_W-1:0] reg1_i,
	input  logic [mips_isa_pkg::REG_W-1:0] reg2_i,
	input  mips_isa_pkg::inst_u            inst_i,
	input  logic [mips_isa_pkg::REG_W-1:0] fwd_hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0] fwd_lo_i,
	output logic [mips_isa_pkg::REG_W-1:0] logic_res_o,
	output logic [mips_isa_pkg::REG_W-1:0] shift_res_o,
	output logic [mips_isa_pkg::REG_W-1:0] arith_res_o,
	output logic [mips_isa_pkg::REG_W-1:0] move_res_o,
	output logic                           ov_o,
	output logic                           trap_o
);

	localparam int MSB = mips_isa_pkg::REG_W - 1;
	localparam int EXT_W = mips_isa_pkg::REG_W - mips_isa_pkg::IMM_W;

	logic [MSB:0]                         imm_ext;
	logic [MSB:0]                         opb;	// second operand.
	logic [MSB:0]                         opb_add;	// as seen by the adder.
	logic [MSB:0]                         sum;
	logic [mips_isa_pkg::SHAMT_W-1:0]     sh_amt;
	logic                                 use_imm;
	logic                                 is_sub;
	logic                                 signed_cmp;
	logic                                 lt_s;
	logic                                 lt_u;
	logic                                 lt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand selection.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign imm_ext = {{EXT_W{inst_i.i.imm[mips_isa_pkg::IMM_W-1]}}, inst_i.i.imm};

	assign use_imm = op_i inside {exe_op_pkg::OP_ADDI, exe_op_pkg::OP_ADDIU,
		exe_op_pkg::OP_SLTI, exe_op_pkg::OP_SLTIU, exe_op_pkg::OP_TEQI,
		exe_op_pkg::OP_TNEI, exe_op_pkg::OP_TGEI, exe_op_pkg::OP_TGEIU,
		exe_op_pkg::OP_TLTI, exe_op_pkg::OP_TLTIU};

	assign opb = use_imm ? imm_ext : reg2_i;

	// constant shifts read shamt, the V forms take rs.
	assign sh_amt = (op_i inside {exe_op_pkg::OP_SLL, exe_op_pkg::OP_SRL, exe_op_pkg::OP_SRA}) ?
		inst_i.r.shamt : reg1_i[mips_isa_pkg::SHAMT_W-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shared adder and compare.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign signed_cmp = op_i inside {exe_op_pkg::OP_SLT, exe_op_pkg::OP_SLTI,
		exe_op_pkg::OP_TLT, exe_op_pkg::OP_TLTI, exe_op_pkg::OP_TGE, exe_op_pkg::OP_TGEI};
	assign is_sub = signed_cmp || (op_i inside {exe_op_pkg::OP_SUB, exe_op_pkg::OP_SUBU});

	assign opb_add = is_sub ? (~opb + 1'b1) : opb;
	assign sum     = reg1_i + opb_add;

	assign lt_s = (reg1_i[MSB] && !opb[MSB]) ||
		(!reg1_i[MSB] && !opb[MSB] && sum[MSB]) ||
		(reg1_i[MSB] && opb[MSB] && sum[MSB]);
	assign lt_u = reg1_i < opb;
	assign lt   = signed_cmp ? lt_s : lt_u;

	// sign of the added operand taken before negation, so b = 0x80000000 still works.
	assign ov_o = (op_i inside {exe_op_pkg::OP_ADD, exe_op_pkg::OP_ADDI, exe_op_pkg::OP_SUB}) &&
		(reg1_i[MSB] == (opb[MSB] ^ is_sub)) && (sum[MSB] != reg1_i[MSB]);

	always_comb begin
		case (op_i)
			exe_op_pkg::OP_TEQ, exe_op_pkg::OP_TEQI:   trap_o = (reg1_i == opb);
			exe_op_pkg::OP_TNE, exe_op_pkg::OP_TNEI:   trap_o = (reg1_i != opb);
			exe_op_pkg::OP_TGE, exe_op_pkg::OP_TGEI,
			exe_op_pkg::OP_TGEU, exe_op_pkg::OP_TGEIU: trap_o = !lt;
			exe_op_pkg::OP_TLT, exe_op_pkg::OP_TLTI,
			exe_op_pkg::OP_TLTU, exe_op_pkg::OP_TLTIU: trap_o = lt;
			default:                                   trap_o = 1'b0;
		endcase
	end

	always_comb begin
		case (op_i)
			exe_op_pkg::OP_SLT, exe_op_pkg::OP_SLTU,
			exe_op_pkg::OP_SLTI, exe_op_pkg::OP_SLTIU: arith_res_o = {{MSB{1'b0}}, lt};
			exe_op_pkg::OP_ADD, exe_op_pkg::OP_ADDU,
			exe_op_pkg::OP_ADDI, exe_op_pkg::OP_ADDIU,
			exe_op_pkg::OP_SUB, exe_op_pkg::OP_SUBU:   arith_res_o = sum;
			default:                                   arith_res_o = '0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// logic, shift and move.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (op_i)
			exe_op_pkg::OP_OR:  logic_res_o = reg1_i | opb;
			exe_op_pkg::OP_AND: logic_res_o = reg1_i & opb;
			exe_op_pkg::OP_NOR: logic_res_o = ~(reg1_i | opb);
			exe_op_pkg::OP_XOR: logic_res_o = reg1_i ^ opb;
			default:            logic_res_o = '0;
		endcase
	end

	always_comb begin
		case (op_i)
			exe_op_pkg::OP_SLL, exe_op_pkg::OP_SLLV: shift_res_o = reg2_i << sh_amt;
			exe_op_pkg::OP_SRL, exe_op_pkg::OP_SRLV: shift_res_o = reg2_i >> sh_amt;
			exe_op_pkg::OP_SRA, exe_op_pkg::OP_SRAV: shift_res_o = $signed(reg2_i) >>> sh_amt;
			default:                                 shift_res_o = '0;
		endcase
	end

	always_comb begin
		case (op_i)
			exe_op_pkg::OP_MFHI:                     move_res_o = fwd_hi_i;
			exe_op_pkg::OP_MFLO:                     move_res_o = fwd_lo_i;
			exe_op_pkg::OP_MTHI, exe_op_pkg::OP_MTLO: move_res_o = reg1_i;	// hilo only.
			default:                                 move_res_o = '0;
		endcase
	end

	always_comb begin
		assert final (!(ov_o && (op_i inside {exe_op_pkg::OP_ADDU, exe_op_pkg::OP_ADDIU,
			exe_op_pkg::OP_SUBU})))
		else $error("exe_alu: overflow raised for unsigned op %h", op_i);
	end

endmodule

//--- verilog/exe_mult.sv
`timescale 1ns/1ps

module exe_mult (
	input  logic [exe_op_pkg::OP_W-1:0]      op_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   reg1_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   reg2_i,
	output logic [2*mips_isa_pkg::REG_W-1:0] prod_o
);

	localparam int MSB = mips_isa_pkg::REG_W - 1;

	logic                                 is_signed;
	logic                                 neg;
	logic [MSB:0]                         mag_a;
	logic [MSB:0]                         mag_b;
	logic [2*mips_isa_pkg::REG_W-1:0]     prod_mag;

	assign is_signed = (op_i == exe_op_pkg::OP_MULT);

	// magnitudes for the signed case, 0x80000000 maps to 2^31 unsigned.
	assign mag_a = (is_signed && reg1_i[MSB]) ? (~reg1_i + 1'b1) : reg1_i;
	assign mag_b = (is_signed && reg2_i[MSB]) ? (~reg2_i + 1'b1) : reg2_i;

	assign prod_mag = {{mips_isa_pkg::REG_W{1'b0}}, mag_a} *
		{{mips_isa_pkg::REG_W{1'b0}}, mag_b};

	assign neg = is_signed && (reg1_i[MSB] ^ reg2_i[MSB]);	// signs differ.

	// a pipelined multiplier would drop in here.
	assign prod_o = neg ? (~prod_mag + 1'b1) : prod_mag;

endmodule

//--- verilog/exe_hilo.sv
`timescale 1ns/1ps

module exe_hilo (
	input  logic [exe_op_pkg::OP_W-1:0]      op_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   reg1_i,
	input  logic [2*mips_isa_pkg::REG_W-1:0] prod_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   lo_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   mem_hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   mem_lo_i,
	input  logic                             mem_whilo_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   wb_hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0]   wb_lo_i,
	input  logic                             wb_whilo_i,
	output logic [mips_isa_pkg::REG_W-1:0]   fwd_hi_o,
	output logic [mips_isa_pkg::REG_W-1:0]   fwd_lo_o,
	output logic                             hilo_we_o,
	output logic [mips_isa_pkg::REG_W-1:0]   hi_wdata_o,
	output logic [mips_isa_pkg::REG_W-1:0]   lo_wdata_o
);

	// newest pair wins, memory stage first.
	always_comb begin
		if (mem_whilo_i) begin
			fwd_hi_o = mem_hi_i;
			fwd_lo_o = mem_lo_i;
		end else if (wb_whilo_i) begin
			fwd_hi_o = wb_hi_i;
			fwd_lo_o = wb_lo_i;
		end else begin
			fwd_hi_o = hi_i;	// committed.
			fwd_lo_o = lo_i;
		end
	end

	always_comb begin
		case (op_i)
			exe_op_pkg::OP_MULT, exe_op_pkg::OP_MULTU: begin
				hilo_we_o  = 1'b1;
				hi_wdata_o = prod_i[2*mips_isa_pkg::REG_W-1:mips_isa_pkg::REG_W];
				lo_wdata_o = prod_i[mips_isa_pkg::REG_W-1:0];
			end
			exe_op_pkg::OP_MTHI: begin
				hilo_we_o  = 1'b1;
				hi_wdata_o = reg1_i;
				lo_wdata_o = fwd_lo_o;	// other half kept.
			end
			exe_op_pkg::OP_MTLO: begin
				hilo_we_o  = 1'b1;
				hi_wdata_o = fwd_hi_o;
				lo_wdata_o = reg1_i;
			end
			default: begin
				hilo_we_o  = 1'b0;
				hi_wdata_o = '0;
				lo_wdata_o = '0;
			end
		endcase
	end

	always_comb begin
		assert final (!hilo_we_o || (op_i inside {exe_op_pkg::OP_MULT, exe_op_pkg::OP_MULTU,
			exe_op_pkg::OP_MTHI, exe_op_pkg::OP_MTLO}))
		else $error("exe_hilo: hilo write requested by op %h", op_i);
	end

endmodule

//--- verilog/exe_writeback.sv
`timescale 1ns/1ps

module exe_writeback (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               valid_i,
	input  logic [exe_op_pkg::TYPE_W-1:0]      type_i,
	input  logic [mips_isa_pkg::RADDR_W-1:0]   waddr_i,
	input  logic                               wena_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     except_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     logic_res_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     shift_res_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     arith_res_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     move_res_i,
	input  logic                               ov_i,
	input  logic                               trap_i,
	input  logic                               hilo_we_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     hi_wdata_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     lo_wdata_i,
	output logic                               valid_o,
	output logic                               wena_o,
	output logic [mips_isa_pkg::RADDR_W-1:0]   waddr_o,
	output logic [mips_isa_pkg::REG_W-1:0]     wdata_o,
	output logic                               hilo_ena_o,
	output logic [mips_isa_pkg::REG_W-1:0]     hi_o,
	output logic [mips_isa_pkg::REG_W-1:0]     lo_o,
	output logic [mips_isa_pkg::REG_W-1:0]     except_o
);

	logic [mips_isa_pkg::REG_W-1:0] wdata;
	logic [mips_isa_pkg::REG_W-1:0] exc_merged;

	always_comb begin
		case (type_i)
			exe_op_pkg::TYPE_LOGIC: wdata = logic_res_i;
			exe_op_pkg::TYPE_SHIFT: wdata = shift_res_i;
			exe_op_pkg::TYPE_ARITH: wdata = arith_res_i;
			exe_op_pkg::TYPE_MOVE:  wdata = move_res_i;
			default:                wdata = '0;	// TYPE_NONE.
		endcase
	end

	// upper bits pass, flags land in 11 and 10, low byte cleared.
	always_comb begin
		exc_merged                             = except_i;
		exc_merged[exe_op_pkg::EXC_OV_BIT]     = ov_i;
		exc_merged[exe_op_pkg::EXC_TRAP_BIT]   = trap_i;
		exc_merged[exe_op_pkg::EXC_CLEAR_W-1:0] = '0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst) begin
			valid_o    <= 1'b0;
			wena_o     <= 1'b0;
			hilo_ena_o <= 1'b0;
			waddr_o    <= '0;
			wdata_o    <= '0;
			hi_o       <= '0;
			lo_o       <= '0;
			except_o   <= '0;
		end else begin
			valid_o    <= valid_i;
			wena_o     <= valid_i && wena_i && !ov_i;	// overflow drops the write.
			hilo_ena_o <= valid_i && hilo_we_i;
			if (valid_i) begin
				waddr_o  <= waddr_i;
				wdata_o  <= wdata;
				hi_o     <= hi_wdata_i;
				lo_o     <= lo_wdata_i;
				except_o <= exc_merged;
			end
		end
	end

	a_ena_valid: assert property (@(posedge clk) disable iff (!rst)
		(wena_o || hilo_ena_o) |-> valid_o)
	else $error("exe_writeback: write enable without valid");

endmodule

//--- verilog/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               valid_i,
	input  logic [exe_op_pkg::OP_W-1:0]        op_i,
	input  logic [exe_op_pkg::TYPE_W-1:0]      type_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     reg1_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     reg2_i,
	input  mips_isa_pkg::inst_u                inst_i,
	input  logic [mips_isa_pkg::RADDR_W-1:0]   waddr_i,
	input  logic                               wena_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     except_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     lo_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     mem_hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     mem_lo_i,
	input  logic                               mem_whilo_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     wb_hi_i,
	input  logic [mips_isa_pkg::REG_W-1:0]     wb_lo_i,
	input  logic                               wb_whilo_i,
	output logic                               valid_o,
	output logic                               wena_o,
	output logic [mips_isa_pkg::RADDR_W-1:0]   waddr_o,
	output logic [mips_isa_pkg::REG_W-1:0]     wdata_o,
	output logic                               hilo_ena_o,
	output logic [mips_isa_pkg::REG_W-1:0]     hi_o,
	output logic [mips_isa_pkg::REG_W-1:0]     lo_o,
	output logic [mips_isa_pkg::REG_W-1:0]     except_o
);

	logic [mips_isa_pkg::REG_W-1:0]   logic_res;
	logic [mips_isa_pkg::REG_W-1:0]   shift_res;
	logic [mips_isa_pkg::REG_W-1:0]   arith_res;
	logic [mips_isa_pkg::REG_W-1:0]   move_res;
	logic                             ov;
	logic                             trap;
	logic [2*mips_isa_pkg::REG_W-1:0] prod;
	logic [mips_isa_pkg::REG_W-1:0]   fwd_hi;
	logic [mips_isa_pkg::REG_W-1:0]   fwd_lo;
	logic                             hilo_we;
	logic [mips_isa_pkg::REG_W-1:0]   hi_wdata;
	logic [mips_isa_pkg::REG_W-1:0]   lo_wdata;

	exe_alu u_alu (
		.op_i(op_i), .reg1_i(reg1_i), .reg2_i(reg2_i), .inst_i(inst_i),
		.fwd_hi_i(fwd_hi), .fwd_lo_i(fwd_lo),
		.logic_res_o(logic_res), .shift_res_o(shift_res), .arith_res_o(arith_res),
		.move_res_o(move_res), .ov_o(ov), .trap_o(trap)
	);

	exe_mult u_mult (
		.op_i(op_i), .reg1_i(reg1_i), .reg2_i(reg2_i), .prod_o(prod)
	);

	exe_hilo u_hilo (
		.op_i(op_i), .reg1_i(reg1_i), .prod_i(prod), .hi_i(hi_i), .lo_i(lo_i),
		.mem_hi_i(mem_hi_i), .mem_lo_i(mem_lo_i), .mem_whilo_i(mem_whilo_i),
		.wb_hi_i(wb_hi_i), .wb_lo_i(wb_lo_i), .wb_whilo_i(wb_whilo_i),
		.fwd_hi_o(fwd_hi), .fwd_lo_o(fwd_lo), .hilo_we_o(hilo_we),
		.hi_wdata_o(hi_wdata), .lo_wdata_o(lo_wdata)
	);

	// the only clocked unit.
	exe_writeback u_wb (
		.clk(clk), .rst(rst), .valid_i(valid_i), .type_i(type_i),
		.waddr_i(waddr_i), .wena_i(wena_i), .except_i(except_i),
		.logic_res_i(logic_res), .shift_res_i(shift_res), .arith_res_i(arith_res),
		.move_res_i(move_res), .ov_i(ov), .trap_i(trap),
		.hilo_we_i(hilo_we), .hi_wdata_i(hi_wdata), .lo_wdata_i(lo_wdata),
		.valid_o(valid_o), .wena_o(wena_o), .waddr_o(waddr_o), .wdata_o(wdata_o),
		.hilo_ena_o(hilo_ena_o), .hi_o(hi_o), .lo_o(lo_o), .except_o(except_o)
	);

endmodule

//--- bench/exe_clkgen.sv
`timescale 1ns/1ps

module exe_clkgen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;	// 10 ns period.
	end

	// reset held low for four rising edges.
	initial begin
		rst_o = 1'b0;
		repeat (4) @(posedge clk_o);
		rst_o <= 1'b1;
	end

endmodule

//--- bench/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb;

	localparam int W = mips_isa_pkg::REG_W;
	localparam int N_INSTR = 40 + 19 + 12 + 36 + 12 + 16;
	localparam int MAX_CYCLES = 4 + N_INSTR + 7 * 2 + 20;	// reset, issue, drain, margin.

	logic clk, rst, valid, wena, mem_whilo, wb_whilo;
	logic [exe_op_pkg::OP_W-1:0] op;
	logic [exe_op_pkg::TYPE_W-1:0] typ;
	logic [W-1:0] reg1, reg2, except, hi, lo, mem_hi, mem_lo, wb_hi, wb_lo;
	logic [mips_isa_pkg::RADDR_W-1:0] waddr, dut_waddr;
	mips_isa_pkg::inst_u inst;
	logic dut_valid, dut_wena, dut_hilo;
	logic [W-1:0] dut_wdata, dut_hi, dut_lo, dut_exc;

	// expected values set at issue and moved along with the DUT register.
	logic e_chk_n, e_wena_n, e_hilo_n, e_chk_c, e_wena_c, e_hilo_c;
	logic [W-1:0] e_wdata_n, e_hi_n, e_lo_n, e_exc_n, e_wdata_c, e_hi_c, e_lo_c, e_exc_c;
	logic [mips_isa_pkg::RADDR_W-1:0] e_waddr_n, e_waddr_c;
	string e_name_n, e_name_c, test_name;
	int seed, errors, test_err0, n_ok, n_bad, cycles;

	exe_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

	exe_stage exe_stage_i (
		.clk(clk), .rst(rst), .valid_i(valid), .op_i(op), .type_i(typ),
		.reg1_i(reg1), .reg2_i(reg2), .inst_i(inst), .waddr_i(waddr), .wena_i(wena),
		.except_i(except), .hi_i(hi), .lo_i(lo), .mem_hi_i(mem_hi), .mem_lo_i(mem_lo),
		.mem_whilo_i(mem_whilo), .wb_hi_i(wb_hi), .wb_lo_i(wb_lo), .wb_whilo_i(wb_whilo),
		.valid_o(dut_valid), .wena_o(dut_wena), .waddr_o(dut_waddr), .wdata_o(dut_wdata),
		.hilo_ena_o(dut_hilo), .hi_o(dut_hi), .lo_o(dut_lo), .except_o(dut_exc)
	);

	always @(posedge clk) begin
		e_chk_c  <= e_chk_n;
		e_wena_c <= e_wena_n;
		e_hilo_c <= e_hilo_n;
		e_waddr_c <= e_waddr_n;
		e_wdata_c <= e_wdata_n;
		e_hi_c   <= e_hi_n;
		e_lo_c   <= e_lo_n;
		e_exc_c  <= e_exc_n;
		e_name_c <= e_name_n;
	end

	task automatic value_error(input string field, input logic [W-1:0] expv,
			input logic [W-1:0] actv);
		$display("** Error %s %s: expected %h, actual %h", e_name_c, field, expv, actv);
		errors++;
	endtask

	task automatic plain_error(input string msg);
		$display("%s: %s", test_name, msg);
		errors++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks sampled mid cycle where outputs are settled.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_valid: assert property (@(negedge clk) disable iff (!rst) e_chk_c |-> dut_valid)
	else plain_error("valid_o stayed low one cycle after issue");
	a_idle: assert property (@(negedge clk) disable iff (!rst)
		!e_chk_c |-> (!dut_valid && !dut_wena && !dut_hilo))
	else plain_error("valid or an enable is high with nothing issued");
	a_wena: assert property (@(negedge clk) disable iff (!rst)
		e_chk_c |-> (dut_wena == e_wena_c))
	else value_error("wena_o", 32'(e_wena_c), 32'(dut_wena));
	a_waddr: assert property (@(negedge clk) disable iff (!rst)
		e_chk_c |-> (dut_waddr == e_waddr_c))
	else value_error("waddr_o", 32'(e_waddr_c), 32'(dut_waddr));
	a_wdata: assert property (@(negedge clk) disable iff (!rst)
		(e_chk_c && e_wena_c) |-> (dut_wdata == e_wdata_c))
	else value_error("wdata_o", e_wdata_c, dut_wdata);
	a_hilo: assert property (@(negedge clk) disable iff (!rst)
		e_chk_c |-> (dut_hilo == e_hilo_c))
	else value_error("hilo_ena_o", 32'(e_hilo_c), 32'(dut_hilo));
	a_hi: assert property (@(negedge clk) disable iff (!rst)
		(e_chk_c && e_hilo_c) |-> (dut_hi == e_hi_c))
	else value_error("hi_o", e_hi_c, dut_hi);
	a_lo: assert property (@(negedge clk) disable iff (!rst)
		(e_chk_c && e_hilo_c) |-> (dut_lo == e_lo_c))
	else value_error("lo_o", e_lo_c, dut_lo);
	a_exc: assert property (@(negedge clk) disable iff (!rst)
		e_chk_c |-> (dut_exc == e_exc_c))
	else value_error("except_o", e_exc_c, dut_exc);

	// result type per op as the decoder sets it.
	function automatic logic [exe_op_pkg::TYPE_W-1:0] type_of(input logic [7:0] o);
		if (o inside {exe_op_pkg::OP_OR, exe_op_pkg::OP_AND, exe_op_pkg::OP_NOR,
				exe_op_pkg::OP_XOR})
			return exe_op_pkg::TYPE_LOGIC;
		if (o inside {exe_op_pkg::OP_SLL, exe_op_pkg::OP_SRL, exe_op_pkg::OP_SRA,
				exe_op_pkg::OP_SLLV, exe_op_pkg::OP_SRLV, exe_op_pkg::OP_SRAV})
			return exe_op_pkg::TYPE_SHIFT;
		if (o inside {exe_op_pkg::OP_ADD, exe_op_pkg::OP_ADDU, exe_op_pkg::OP_ADDI,
				exe_op_pkg::OP_ADDIU, exe_op_pkg::OP_SUB, exe_op_pkg::OP_SUBU,
				exe_op_pkg::OP_SLT, exe_op_pkg::OP_SLTU, exe_op_pkg::OP_SLTI,
				exe_op_pkg::OP_SLTIU})
			return exe_op_pkg::TYPE_ARITH;
		if (o inside {exe_op_pkg::OP_MFHI, exe_op_pkg::OP_MFLO, exe_op_pkg::OP_MTHI,
				exe_op_pkg::OP_MTLO})
			return exe_op_pkg::TYPE_MOVE;
		return exe_op_pkg::TYPE_NONE;
	endfunction

	// drives one instruction and works out what it should produce.
	task automatic issue(input logic [7:0] o, input logic [W-1:0] a, input logic [W-1:0] b,
			input logic [15:0] imm, input logic [4:0] sa, input logic we);
		logic [W-1:0] bi;
		logic [W-1:0] res;
		logic [W-1:0] fh;
		logic [W-1:0] fl;
		logic [63:0] prod;
		logic [4:0] sh;
		longint s;
		logic ov;
		logic tr;
		logic is_imm;
		is_imm = o inside {exe_op_pkg::OP_ADDI, exe_op_pkg::OP_ADDIU, exe_op_pkg::OP_SLTI,
			exe_op_pkg::OP_SLTIU, exe_op_pkg::OP_TEQI, exe_op_pkg::OP_TNEI,
			exe_op_pkg::OP_TGEI, exe_op_pkg::OP_TGEIU, exe_op_pkg::OP_TLTI,
			exe_op_pkg::OP_TLTIU};
		bi = is_imm ? {{16{imm[15]}}, imm} : b;	// immediates always sign-extended.
		sh = (o inside {exe_op_pkg::OP_SLL, exe_op_pkg::OP_SRL, exe_op_pkg::OP_SRA}) ? sa : a[4:0];
		fh = mem_whilo ? mem_hi : (wb_whilo ? wb_hi : hi);
		fl = mem_whilo ? mem_lo : (wb_whilo ? wb_lo : lo);
		res = '0;
		prod = '0;
		ov = 1'b0;
		tr = 1'b0;
		case (o)
			exe_op_pkg::OP_OR:  res = a | bi;
			exe_op_pkg::OP_AND: res = a & bi;
			exe_op_pkg::OP_NOR: res = ~(a | bi);
			exe_op_pkg::OP_XOR: res = a ^ bi;
			exe_op_pkg::OP_SLL, exe_op_pkg::OP_SLLV: res = b << sh;
			exe_op_pkg::OP_SRL, exe_op_pkg::OP_SRLV: res = b >> sh;
			exe_op_pkg::OP_SRA, exe_op_pkg::OP_SRAV: res = $unsigned($signed(b) >>> sh);
			exe_op_pkg::OP_ADD, exe_op_pkg::OP_ADDU, exe_op_pkg::OP_ADDI,
			exe_op_pkg::OP_ADDIU, exe_op_pkg::OP_SUB, exe_op_pkg::OP_SUBU: begin
				if (o inside {exe_op_pkg::OP_SUB, exe_op_pkg::OP_SUBU})
					s = longint'($signed(a)) - longint'($signed(bi));
				else
					s = longint'($signed(a)) + longint'($signed(bi));
				res = s[31:0];
				// overflow when the exact sum does not fit in 32 signed bits.
				ov = (o inside {exe_op_pkg::OP_ADD, exe_op_pkg::OP_ADDI, exe_op_pkg::OP_SUB}) &&
					(s != longint'($signed(res)));
			end
			exe_op_pkg::OP_SLT, exe_op_pkg::OP_SLTI:   res = {31'b0, $signed(a) < $signed(bi)};
			exe_op_pkg::OP_SLTU, exe_op_pkg::OP_SLTIU: res = {31'b0, a < bi};
			exe_op_pkg::OP_TEQ, exe_op_pkg::OP_TEQI:   tr = (a == bi);
			exe_op_pkg::OP_TNE, exe_op_pkg::OP_TNEI:   tr = (a != bi);
			exe_op_pkg::OP_TGE, exe_op_pkg::OP_TGEI:   tr = ($signed(a) >= $signed(bi));
			exe_op_pkg::OP_TGEU, exe_op_pkg::OP_TGEIU: tr = (a >= bi);
			exe_op_pkg::OP_TLT, exe_op_pkg::OP_TLTI:   tr = ($signed(a) < $signed(bi));
			exe_op_pkg::OP_TLTU, exe_op_pkg::OP_TLTIU: tr = (a < bi);
			exe_op_pkg::OP_MULT:  prod = longint'($signed(a)) * longint'($signed(b));
			exe_op_pkg::OP_MULTU: prod = {32'b0, a} * {32'b0, b};
			exe_op_pkg::OP_MFHI:  res = fh;
			exe_op_pkg::OP_MFLO:  res = fl;
			exe_op_pkg::OP_MTHI:  prod = {a, fl};
			exe_op_pkg::OP_MTLO:  prod = {fh, a};
			default: ;
		endcase
		op = o;
		typ = type_of(o);
		reg1 = a;
		reg2 = b;
		inst = '0;
		inst.r.shamt = sa;
		if (is_imm)
			inst.i.imm = imm;
		valid = 1'b1;
		wena = we;
		waddr = 5'($random(seed));
		except = $random(seed);
		e_chk_n = 1'b1;
		e_name_n = test_name;
		e_wena_n = we && !ov;
		e_waddr_n = waddr;
		e_wdata_n = res;
		e_hilo_n = o inside {exe_op_pkg::OP_MULT, exe_op_pkg::OP_MULTU, exe_op_pkg::OP_MTHI,
			exe_op_pkg::OP_MTLO};
		e_hi_n = prod[63:32];
		e_lo_n = prod[31:0];
		e_exc_n = {except[31:12], ov, tr, except[9:8], 8'h00};
		@(posedge clk);
		#1;
	endtask

	task automatic start_test(input string n);
		test_name = n;
		test_err0 = errors;
	endtask

	// two idle cycles let the last result and the idle state be checked.
	task automatic end_test;
		valid = 1'b0;
		wena = 1'b0;
		e_chk_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		if (errors == test_err0) begin
			n_ok++;
			$display("test %-10s ok", test_name);
		end else begin
			n_bad++;
			$display("test %-10s FAIL, %0d errors", test_name, errors - test_err0);
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles <= MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [4:0] sa;
		logic [7:0] trap_ops [12];
		logic [W-1:0] pa [3];
		logic [W-1:0] pb [3];
		seed = 32'h930e_643b;
		errors = 0;
		n_ok = 0;
		n_bad = 0;
		valid = 1'b0;
		wena = 1'b0;
		op = exe_op_pkg::OP_NOP;
		typ = exe_op_pkg::TYPE_NONE;
		reg1 = '0;
		reg2 = '0;
		inst = '0;
		waddr = '0;
		except = '0;
		hi = '0;
		lo = '0;
		mem_hi = '0;
		mem_lo = '0;
		mem_whilo = 1'b0;
		wb_hi = '0;
		wb_lo = '0;
		wb_whilo = 1'b0;
		e_chk_n = 1'b0;
		e_wena_n = 1'b0;
		e_hilo_n = 1'b0;
		e_waddr_n = '0;
		e_wdata_n = '0;
		e_hi_n = '0;
		e_lo_n = '0;
		e_exc_n = '0;
		e_name_n = "";
		wait (rst == 1'b1);
		@(posedge clk);
		#1;

		start_test("reset");
		a_rst: assert (!dut_valid && !dut_wena && !dut_hilo && dut_wdata == '0 &&
			dut_waddr == '0 && dut_hi == '0 && dut_lo == '0 && dut_exc == '0)
		else plain_error("outputs not cleared by reset");
		end_test();

		start_test("logic_sh");
		for (int i = 0; i < 4; i++) begin
			a = $random(seed);
			b = $random(seed);
			sa = 5'($random(seed));
			issue(exe_op_pkg::OP_OR, a, b, '0, '0, 1'b1);
			issue(exe_op_pkg::OP_AND, a, b, '0, '0, 1'b1);
			issue(exe_op_pkg::OP_NOR, a, b, '0, '0, 1'b1);
			issue(exe_op_pkg::OP_XOR, a, b, '0, '0, i[0]);
			issue(exe_op_pkg::OP_SLL, a, b, '0, sa, 1'b1);
			issue(exe_op_pkg::OP_SRL, a, b, '0, sa, 1'b1);
			issue(exe_op_pkg::OP_SRA, a, b | 32'h8000_0000, '0, sa, 1'b1);	// negative.
			issue(exe_op_pkg::OP_SLLV, a, b, '0, sa, 1'b1);
			issue(exe_op_pkg::OP_SRLV, a, b, '0, sa, 1'b1);
			issue(exe_op_pkg::OP_SRAV, a, b | 32'h8000_0000, '0, sa, 1'b1);
		end
		end_test();

		start_test("add_sub");
		issue(exe_op_pkg::OP_ADD, 32'h7fff_ffff, 32'h1, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_ADDU, 32'h7fff_ffff, 32'h1, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_ADDU, 32'h8000_0000, 32'h8000_0000, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_SUB, 32'h8000_0000, 32'h1, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_SUBU, 32'h8000_0000, 32'h1, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_SUB, 32'h0, 32'h8000_0000, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_SUBU, 32'h0, 32'h8000_0000, '0, '0, 1'b1);
		issue(exe_op_pkg::OP_ADDI, 32'h7fff_fff0, '0, 16'h0010, '0, 1'b1);
		issue(exe_op_pkg::OP_ADDIU, 32'h7fff_fff0, '0, 16'h0010, '0, 1'b1);
		issue(exe_op_pkg::OP_ADDI, 32'h5, '0, 16'hffff, '0, 1'b1);
		for (int i = 0; i < 4; i++) begin
			issue(exe_op_pkg::OP_ADD, $random(seed), $random(seed), '0, '0, 1'b1);
			issue(exe_op_pkg::OP_SUB, $random(seed), $random(seed), '0, '0, 1'b1);
		end
		end_test();

		start_test("slt");
		pa = '{32'hffff_ffff, 32'h0000_0001, $random(seed)};
		pb = '{32'h0000_0001, 32'hffff_ffff, $random(seed)};
		for (int i = 0; i < 3; i++) begin
			issue(exe_op_pkg::OP_SLT, pa[i], pb[i], '0, '0, 1'b1);
			issue(exe_op_pkg::OP_SLTU, pa[i], pb[i], '0, '0, 1'b1);
			issue(exe_op_pkg::OP_SLTI, pa[i], '0, pb[i][15:0], '0, 1'b1);
			issue(exe_op_pkg::OP_SLTIU, pa[i], '0, pb[i][15:0], '0, 1'b1);
		end
		end_test();

		// equal, signed negative and unsigned large operand pairs.
		start_test("trap");
		trap_ops = '{exe_op_pkg::OP_TEQ, exe_op_pkg::OP_TNE, exe_op_pkg::OP_TGE,
			exe_op_pkg::OP_TGEU, exe_op_pkg::OP_TLT, exe_op_pkg::OP_TLTU,
			exe_op_pkg::OP_TEQI, exe_op_pkg::OP_TNEI, exe_op_pkg::OP_TGEI,
			exe_op_pkg::OP_TGEIU, exe_op_pkg::OP_TLTI, exe_op_pkg::OP_TLTIU};
		pa = '{32'h0000_0005, 32'hffff_fffd, 32'h0000_0001};
		pb = '{32'h0000_0005, 32'h0000_0004, 32'hffff_fff0};
		for (int i = 0; i < 3; i++)
			for (int k = 0; k < 12; k++)
				issue(trap_ops[k], pa[i], pb[i], pb[i][15:0], '0, 1'b0);
		end_test();

		start_test("mult");
		pa = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff};
		pb = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0002};
		for (int i = 0; i < 6; i++) begin
			a = (i < 3) ? pa[i] : $random(seed);
			b = (i < 3) ? pb[i] : $random(seed);
			issue(exe_op_pkg::OP_MULT, a, b, '0, '0, i[0]);
			issue(exe_op_pkg::OP_MULTU, a, b, '0, '0, i[1]);
		end
		end_test();

		start_test("hilo_fwd");
		for (int k = 0; k < 4; k++) begin
			hi = $random(seed);
			lo = $random(seed);
			mem_hi = $random(seed);
			mem_lo = $random(seed);
			wb_hi = $random(seed);
			wb_lo = $random(seed);
			mem_whilo = k[1];
			wb_whilo = k[0];
			issue(exe_op_pkg::OP_MFHI, '0, '0, '0, '0, 1'b1);
			issue(exe_op_pkg::OP_MFLO, '0, '0, '0, '0, 1'b1);
			issue(exe_op_pkg::OP_MTHI, $random(seed), '0, '0, '0, 1'b0);
			issue(exe_op_pkg::OP_MTLO, $random(seed), '0, '0, '0, 1'b0);
		end
		end_test();

		$display("%0d tests, %0d ok, %0d failing, %0d errors", n_ok + n_bad, n_ok, n_bad,
			errors);
		if (errors == 0 && n_bad == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- flist.f
verilog/mips_isa_pkg.sv
verilog/exe_op_pkg.sv
verilog/exe_alu.sv
verilog/exe_mult.sv
verilog/exe_hilo.sv
verilog/exe_writeback.sv
verilog/exe_stage.sv
bench/exe_clkgen.sv
bench/exe_stage_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = exe_stage_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
